// File: verilog/emesh_pkg.sv
package emesh_pkg;

   // #####################################################################
   // Mesh packet geometry
   // #####################################################################

   localparam int PW = 104;             // Standard mesh packet
   localparam int AW = 32;              // Address width

   // dstaddr[31:20] all zero selects register space
   localparam int REG_SPACE_HI = 31;
   localparam int REG_SPACE_LO = 20;

   // Transfer size, carried through untouched
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   // #####################################################################
   // Packet layout, MSB first
   // #####################################################################

   typedef struct packed {
      logic [AW-1:0] srcaddr;           // [103:72]
      logic [31:0]   data;              // [71:40]
      logic [AW-1:0] dstaddr;           // [39:8]
      logic [4:0]    ctrlmode;          // [7:3]
      datamode_e     datamode;          // [2:1]
      logic          write;             // [0], 1 for write
   } packet_t;

   // Address decode lands on packet bits 39:28

endpackage

// File: verilog/mio_pkg.sv
package mio_pkg;

   // #####################################################################
   // Register map
   // #####################################################################

   // Register index sits in dstaddr[3:2]
   localparam int REG_IDX_HI = 3;
   localparam int REG_IDX_LO = 2;

   typedef enum logic [1:0] {
      CONFIG = 2'd0,                    // Link config, read/write
      CLKDIV = 2'd1,                    // Beat pacing, read/write
      STATUS = 2'd2                     // Counters, read only
   } reg_addr_e;

   localparam int CFG_W      = 18;      // CONFIG width
   localparam int CFG_EN_BIT = 12;      // Link enable
   localparam int CLKDIV_W   = 7;
   localparam int CNT_W      = 16;      // Each STATUS counter half

   // #####################################################################
   // Link state machines
   // #####################################################################

   typedef enum logic [1:0] {
      IDLE = 2'd0,                      // Ready for ingress
      SEND = 2'd1,                      // Beat on the link
      GAP  = 2'd2,                      // Pacing between beats
      DROP = 2'd3                       // Link disabled, discard
   } tx_state_e;

   typedef enum logic {
      COLLECT = 1'b0,                   // Gathering beats
      HOLD    = 1'b1                    // Full packet parked
   } rx_state_e;

endpackage

// File: verilog/mio_tx.sv
module mio_tx #(
   parameter int IOW = 64
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         access_in,
   input  emesh_pkg::packet_t           packet_in,
   input  logic                         reg_wait,
   input  logic                         cfg_en,
   input  logic [mio_pkg::CLKDIV_W-1:0] clkdiv,
   input  logic                         tx_wait,
   output logic                         wait_out,
   output logic                         reg_access,
   output emesh_pkg::packet_t           reg_packet,
   output logic                         tx_access,
   output logic                         tx_first,
   output logic [IOW-1:0]               tx_packet,
   output logic                         pkt_sent,
   output logic                         pkt_drop
);
   import emesh_pkg::*;
   import mio_pkg::*;

   localparam int NB  = (PW + IOW - 1) / IOW;       // Beats per packet
   localparam int BIW = (NB > 1) ? $clog2(NB) : 1;

   tx_state_e           state;
   logic [CLKDIV_W-1:0] pace;        // Gap cycles left
   logic [BIW-1:0]      beat_idx;
   packet_t             pkt_q;       // Packet in flight
   logic [NB*IOW-1:0]   pkt_pad;
   logic                is_reg;
   logic                accept;
   logic                link_accept;
   logic                beat_done;
   logic                last_beat;

   // #####################################################################
   // Ingress decode
   // #####################################################################

   assign is_reg      = ~|packet_in.dstaddr[REG_SPACE_HI:REG_SPACE_LO];
   assign wait_out    = reg_wait | (state != IDLE);   // Busy until last beat
   assign accept      = access_in & ~wait_out;
   assign reg_access  = accept & is_reg;
   assign reg_packet  = packet_in;
   assign link_accept = accept & ~is_reg;

   // #####################################################################
   // Beat selection
   // #####################################################################

   assign tx_access = (state == SEND);
   assign tx_first  = tx_access & (beat_idx == '0);
   assign beat_done = tx_access & ~tx_wait;
   assign last_beat = (beat_idx == BIW'(NB - 1));
   assign pkt_sent  = beat_done & last_beat;          // Counted on final beat
   assign pkt_drop  = (state == DROP);

   // Zero pad up to a whole number of beats
   always_comb begin
      pkt_pad         = '0;
      pkt_pad[PW-1:0] = pkt_q;
   end

   assign tx_packet = pkt_pad[beat_idx*IOW +: IOW];   // LS beat first

   always_ff @(posedge clk) begin
      if (link_accept)
         pkt_q <= packet_in;
   end

   // #####################################################################
   // Pacing FSM, one beat every clkdiv+1 cycles
   // #####################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         pace     <= '0;
         beat_idx <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (link_accept) begin
                  beat_idx <= '0;
                  if (!cfg_en) begin
                     state <= DROP;               // Link off, discard
                  end else if (clkdiv == '0) begin
                     state <= SEND;
                  end else begin
                     state <= GAP;
                     pace  <= clkdiv - 1'b1;
                  end
               end
            end
            SEND: begin
               if (beat_done) begin
                  if (last_beat) begin
                     state <= IDLE;
                  end else begin
                     beat_idx <= beat_idx + 1'b1;
                     if (clkdiv != '0) begin
                        state <= GAP;
                        pace  <= clkdiv - 1'b1;
                     end
                  end
               end                                // Stalled beat holds index
            end
            GAP: begin
               if (pace == '0)
                  state <= SEND;
               else
                  pace <= pace - 1'b1;
            end
            DROP:    state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Stalled beat keeps access and data until rx takes it
   a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
      tx_access && tx_wait |=> tx_access && $stable(tx_packet));

endmodule

// File: verilog/mio_regs.sv
module mio_regs #(
   parameter logic [mio_pkg::CFG_W-1:0]    DEF_CFG = 18'h1070,
   parameter logic [mio_pkg::CLKDIV_W-1:0] DEF_CLK = 7'd7
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         reg_access,
   input  emesh_pkg::packet_t           reg_packet,
   input  logic                         pkt_sent,
   input  logic                         pkt_drop,
   input  logic                         rsp_wait,
   output logic                         reg_wait,
   output logic                         cfg_en,
   output logic [mio_pkg::CLKDIV_W-1:0] clkdiv,
   output logic                         rsp_access,
   output emesh_pkg::packet_t           rsp_packet
);
   import mio_pkg::*;

   logic [CFG_W-1:0] cfg_q;          // Reserved bits kept as written
   logic [CNT_W-1:0] sent_cnt;
   logic [CNT_W-1:0] drop_cnt;
   reg_addr_e        reg_idx;
   logic [31:0]      rd_data;
   logic             wr_en;
   logic             rd_en;

   assign reg_idx = reg_addr_e'(reg_packet.dstaddr[REG_IDX_HI:REG_IDX_LO]);
   assign wr_en   = reg_access & reg_packet.write;
   assign rd_en   = reg_access & ~reg_packet.write;

   assign cfg_en   = cfg_q[CFG_EN_BIT];
   assign reg_wait = rsp_access;      // Block ingress until response leaves

   // #####################################################################
   // Writable registers and counters
   // #####################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_q  <= DEF_CFG;
         clkdiv <= DEF_CLK;
      end else if (wr_en) begin
         case (reg_idx)
            CONFIG:  cfg_q  <= reg_packet.data[CFG_W-1:0];
            CLKDIV:  clkdiv <= reg_packet.data[CLKDIV_W-1:0];
            default: ;                // STATUS and hole ignore writes
         endcase
      end
   end

   // Sent and dropped packet counts, wrap on overflow
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sent_cnt <= '0;
         drop_cnt <= '0;
      end else begin
         if (pkt_sent) sent_cnt <= sent_cnt + 1'b1;
         if (pkt_drop) drop_cnt <= drop_cnt + 1'b1;
      end
   end

   // Read mux
   always_comb begin
      rd_data = '0;
      case (reg_idx)
         CONFIG:  rd_data[CFG_W-1:0]    = cfg_q;
         CLKDIV:  rd_data[CLKDIV_W-1:0] = clkdiv;
         STATUS:  rd_data               = {drop_cnt, sent_cnt};
         default: rd_data               = '0;
      endcase
   end

   // #####################################################################
   // Read response
   // #####################################################################

   always_ff @(posedge clk) begin
      if (!rst_n)
         rsp_access <= 1'b0;
      else if (rd_en)
         rsp_access <= 1'b1;
      else if (!rsp_wait)
         rsp_access <= 1'b0;          // Taken by output stage
   end

   // Addresses swap so the reply heads back to the requester
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rsp_packet.write    <= 1'b0;
         rsp_packet.datamode <= reg_packet.datamode;
         rsp_packet.ctrlmode <= reg_packet.ctrlmode;
         rsp_packet.dstaddr  <= reg_packet.srcaddr;
         rsp_packet.srcaddr  <= reg_packet.dstaddr;
         rsp_packet.data     <= rd_data;
      end
   end

   // Ingress must honor reg_wait through mio_tx
   a_no_access_while_wait: assert property (@(posedge clk) disable iff (!rst_n)
      reg_access |-> !reg_wait);

   // Response held until the output stage takes it
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_access && rsp_wait |=> rsp_access && $stable(rsp_packet));

endmodule

// File: verilog/mio_rx.sv
module mio_rx #(
   parameter int IOW = 64
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               tx_access,
   input  logic               tx_first,
   input  logic [IOW-1:0]     tx_packet,
   input  logic               rsp_access,
   input  emesh_pkg::packet_t rsp_packet,
   input  logic               wait_in,
   output logic               rx_wait,
   output logic               rsp_wait,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out
);
   import emesh_pkg::*;
   import mio_pkg::*;

   localparam int NB  = (PW + IOW - 1) / IOW;       // Beats per packet
   localparam int BIW = (NB > 1) ? $clog2(NB) : 1;

   rx_state_e         state;
   logic [BIW-1:0]    cnt;           // Next beat slot
   logic [BIW-1:0]    wr_idx;
   logic [NB*IOW-1:0] col_q;         // Beats gathered so far
   packet_t           col_pkt;
   logic              beat_in;
   logic              out_free;
   logic              link_load;
   logic              rsp_load;

   // #####################################################################
   // Beat collection
   // #####################################################################

   assign rx_wait = (state == HOLD);  // Full packet parked, no more beats
   assign beat_in = tx_access & ~rx_wait;
   assign wr_idx  = tx_first ? '0 : cnt;               // First beat restarts
   assign col_pkt = col_q[PW-1:0];                     // Drop beat padding

   always_ff @(posedge clk) begin
      if (beat_in)
         col_q[wr_idx*IOW +: IOW] <= tx_packet;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= COLLECT;
         cnt   <= '0;
      end else begin
         case (state)
            COLLECT: begin
               if (beat_in) begin
                  cnt <= wr_idx + 1'b1;
                  if (wr_idx == BIW'(NB - 1))
                     state <= HOLD;           // Last slice stored
               end
            end
            HOLD: begin
               if (out_free) begin
                  state <= COLLECT;
                  cnt   <= '0;
               end
            end
            default: state <= COLLECT;
         endcase
      end
   end

   // #####################################################################
   // Output stage, one packet deep
   // #####################################################################

   assign out_free  = ~access_out | ~wait_in;          // Empty or draining
   assign link_load = (state == HOLD) & out_free;      // Link wins
   assign rsp_load  = rsp_access & out_free & (state != HOLD);
   assign rsp_wait  = ~out_free | (state == HOLD);

   always_ff @(posedge clk) begin
      if (!rst_n)
         access_out <= 1'b0;
      else
         access_out <= link_load | rsp_load | (access_out & wait_in);
   end

   always_ff @(posedge clk) begin
      if (link_load)
         packet_out <= col_pkt;
      else if (rsp_load)
         packet_out <= rsp_packet;
   end

   // Output frozen under back-pressure
   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      access_out && wait_in |=> access_out && $stable(packet_out));

   // Continuation beats only follow a first beat from mio_tx
   a_first_order: assert property (@(posedge clk) disable iff (!rst_n)
      beat_in && !tx_first |-> (cnt != '0));

endmodule

// File: verilog/mio_dut.sv
module mio_dut #(
   parameter int                           IOW     = 64,
   parameter logic [mio_pkg::CFG_W-1:0]    DEF_CFG = 18'h1070,
   parameter logic [mio_pkg::CLKDIV_W-1:0] DEF_CLK = 7'd7
) (
   input  logic               clk1,
   input  logic               rst_n,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in,
   output logic               clkout
);
   import emesh_pkg::*;
   import mio_pkg::*;

   // Register side
   logic                reg_access;
   packet_t             reg_packet;
   logic                reg_wait;
   logic                cfg_en;
   logic [CLKDIV_W-1:0] clkdiv;
   logic                pkt_sent;
   logic                pkt_drop;

   // Read responses toward the output stage
   logic                rsp_access;
   packet_t             rsp_packet;
   logic                rsp_wait;

   // Loopback link
   logic                tx_access;
   logic                tx_first;
   logic [IOW-1:0]      tx_packet;
   logic                rx_wait;

   assign clkout = clk1;              // Forwarded clock

   // #####################################################################
   // Ingress decode and serializer
   // #####################################################################

   mio_tx #(.IOW(IOW)) tx_i (
      .clk        (clk1),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .reg_wait   (reg_wait),
      .cfg_en     (cfg_en),
      .clkdiv     (clkdiv),
      .tx_wait    (rx_wait),          // Loopback wait
      .wait_out   (wait_out),
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .tx_access  (tx_access),
      .tx_first   (tx_first),
      .tx_packet  (tx_packet),
      .pkt_sent   (pkt_sent),
      .pkt_drop   (pkt_drop)
   );

   mio_regs #(.DEF_CFG(DEF_CFG), .DEF_CLK(DEF_CLK)) regs_i (
      .clk        (clk1),
      .rst_n      (rst_n),
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .pkt_sent   (pkt_sent),
      .pkt_drop   (pkt_drop),
      .rsp_wait   (rsp_wait),
      .reg_wait   (reg_wait),
      .cfg_en     (cfg_en),
      .clkdiv     (clkdiv),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet)
   );

   // #####################################################################
   // Deserializer, link looped straight back
   // #####################################################################

   mio_rx #(.IOW(IOW)) rx_i (
      .clk        (clk1),
      .rst_n      (rst_n),
      .tx_access  (tx_access),
      .tx_first   (tx_first),
      .tx_packet  (tx_packet),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet),
      .wait_in    (wait_in),
      .rx_wait    (rx_wait),
      .rsp_wait   (rsp_wait),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: tb/tb_mio_dut.sv
module tb_mio_dut;
   import emesh_pkg::*;

   localparam int                IOW      = 64;
   localparam logic [17:0]       DEF_CFG  = 18'h1070;
   localparam logic [6:0]        DEF_CLK  = 7'd7;
   localparam int                BEATS    = (PW + IOW - 1) / IOW;   // Link beats per packet
   localparam int                TIMEOUT  = 2000;                   // Cycles per wait
   localparam logic [31:0]       REG_CFG  = 32'h0000_0000;
   localparam logic [31:0]       REG_CLK  = 32'h0000_0004;
   localparam logic [31:0]       REG_STAT = 32'h0000_0008;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_LINK, OP_BP} op_e;

   typedef struct packed {
      op_e         op;
      packet_t     pkt;
      logic [31:0] exp_val;              // Read data, or back-pressure on/off
   } entry_t;

   logic    clk1;
   logic    rst_n;
   logic    access_in;
   packet_t packet_in;
   logic    wait_out;
   logic    access_out;
   packet_t packet_out;
   logic    wait_in;
   logic    clkout;

   entry_t     tests[$];
   packet_t    exp_q[$];                 // Outputs still owed by the DUT
   bit         rsp_q[$];                 // Matching read-response flags
   int         errors = 0;
   int         checks = 0;
   int         outputs_seen = 0;
   integer     seed = 50;
   logic       bp_on;                    // Random wait_in while set
   logic       bp_now;
   logic       stalled;
   packet_t    held_pkt;
   logic       model_en;                 // Link enable as last written
   logic [6:0] model_div;                // CLKDIV as last written

   mio_dut #(.IOW(IOW), .DEF_CFG(DEF_CFG), .DEF_CLK(DEF_CLK)) dut_i (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .clkout     (clkout)
   );

   initial begin
      clk1 = 1'b0;
      forever #50 clk1 = ~clk1;
   end

   // ########################################################################
   // Compare tasks and the response rule
   // ########################################################################

   task automatic check_packet(input string name, input packet_t exp, input packet_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s expected %h got %h", name, exp, got);
      end
   endtask

   task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s expected %h got %h", name, exp, got);
      end
   endtask

   task automatic check_quiet(input int cycles);
      int n;
      for (n = 0; n < cycles; n++) begin
         checks++;
         if (access_out) begin
            errors++;
            $display("An output packet appeared where none was expected");
            break;
         end
         @(posedge clk1);
         #10;
      end
   endtask

   // Reply heads back to the requester with the register value
   function automatic packet_t expected_response(input packet_t req, input logic [31:0] value);
      packet_t r;
      r = req;
      r.write = 1'b0;
      r.dstaddr = req.srcaddr;
      r.srcaddr = req.dstaddr;
      r.data = value;
      return r;
   endfunction

   // ########################################################################
   // Stimulus helpers, all entered and left 10 units after an edge
   // ########################################################################

   task automatic send_packet(input packet_t p);
      int n;
      n = 0;
      access_in = 1'b1;
      packet_in = p;
      while (wait_out && n < TIMEOUT) begin
         @(posedge clk1);
         #10;
         n++;
      end
      if (wait_out) begin
         errors++;
         $display("Timeout: wait_out never fell, packet not accepted");
      end
      @(posedge clk1);                   // Transfer edge
      #10;
      access_in = 1'b0;
   endtask

   task automatic wait_rise(output int n);
      n = 0;
      while (!access_out && n < TIMEOUT) begin
         @(posedge clk1);
         #10;
         n++;
      end
      if (!access_out) begin
         errors++;
         $display("Timeout: access_out never rose for a looped-back packet");
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || access_out) && n < TIMEOUT) begin
         @(posedge clk1);
         #10;
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Timeout: %0d expected packets never left the DUT", exp_q.size());
      end
   endtask

   task automatic add_entry(input op_e op, input logic [31:0] dst, input logic [31:0] data,
                            input logic [31:0] exp_val);
      entry_t e;
      int     idx;
      idx = tests.size();
      e.op = op;
      e.pkt.write = (op == OP_WR);
      e.pkt.datamode = datamode_e'(idx[1:0]);
      e.pkt.ctrlmode = idx[4:0];
      e.pkt.dstaddr = dst;
      e.pkt.data = data;
      e.pkt.srcaddr = 32'h5C00_0000 | (idx << 8);
      e.exp_val = exp_val;
      tests.push_back(e);
   endtask

   task automatic build_tests();
      add_entry(OP_RD, REG_CFG, 32'h0, 32'h0000_1070);        // Reset values
      add_entry(OP_RD, REG_CLK, 32'h0, 32'h0000_0007);
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0000_0000);
      add_entry(OP_WR, REG_CFG, 32'hFFF3_F0F3, 32'h0);        // Reserved bits set, enable kept
      add_entry(OP_RD, REG_CFG, 32'h0, 32'h0003_F0F3);
      add_entry(OP_WR, REG_STAT, 32'h0000_1234, 32'h0);       // Read only
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0000_0000);
      add_entry(OP_WR, REG_CLK, 32'hFFFF_FF80, 32'h0);        // CLKDIV 0
      add_entry(OP_RD, REG_CLK, 32'h0, 32'h0000_0000);
      add_entry(OP_LINK, 32'h8000_0010, 32'h1111_1111, 32'h0);
      add_entry(OP_LINK, 32'h0010_0000, 32'hA5A5_5A5A, 32'h0); // Lowest link address bit
      add_entry(OP_WR, REG_CLK, 32'h0000_0007, 32'h0);
      add_entry(OP_RD, REG_CLK, 32'h0, 32'h0000_0007);
      add_entry(OP_LINK, 32'h1230_0004, 32'hDEAD_BEEF, 32'h0);
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0000_0003);
      add_entry(OP_BP, 32'h0, 32'h0, 32'h1);                  // Burst under back-pressure
      add_entry(OP_LINK, 32'hFFF0_0008, 32'h0BAD_F00D, 32'h0);
      add_entry(OP_RD, REG_CFG, 32'h0, 32'h0003_F0F3);
      add_entry(OP_LINK, 32'h4000_0000, 32'h1357_9BDF, 32'h0);
      add_entry(OP_LINK, 32'h7FF0_FFFC, 32'h2468_ACE0, 32'h0);
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0000_0006);
      add_entry(OP_BP, 32'h0, 32'h0, 32'h0);
      add_entry(OP_WR, REG_CFG, 32'h0000_0070, 32'h0);        // Link off
      add_entry(OP_LINK, 32'h9000_0000, 32'hCAFE_0001, 32'h0);
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0001_0006);       // One drop
      add_entry(OP_WR, REG_CFG, 32'h0000_1070, 32'h0);        // Link back on
      add_entry(OP_LINK, 32'h9000_0004, 32'hCAFE_0002, 32'h0);
      add_entry(OP_RD, REG_STAT, 32'h0, 32'h0001_0007);
   endtask

   // ########################################################################
   // Output side: random wait_in, stall check, in-order compare
   // ########################################################################

   always begin
      @(posedge clk1);
      bp_now = bp_on;
      #10;
      if (stalled) begin
         if (!access_out)
            $display("access_out dropped while wait_in held the packet");
         if (!access_out)
            errors++;
         check_packet("packet_out", held_pkt, packet_out);   // Frozen while stalled
      end
      wait_in = bp_now ? 1'($random(seed)) : 1'b0;
      stalled = access_out && wait_in;
      if (stalled) begin
         held_pkt = packet_out;
      end else if (access_out) begin
         outputs_seen++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected packet on the output: %h", packet_out);
         end else if (rsp_q.pop_front()) begin
            check_data("packet_out.data", exp_q[0].data, packet_out.data);
            check_packet("packet_out", exp_q.pop_front(), packet_out);
         end else begin
            check_packet("packet_out", exp_q.pop_front(), packet_out);
         end
      end
   end

   // ########################################################################
   // Main sequence
   // ########################################################################

   initial begin
      entry_t e;
      op_e    op;
      int     err0;
      int     lat;
      rst_n = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      bp_on = 1'b0;
      stalled = 1'b0;
      model_en = DEF_CFG[12];
      model_div = DEF_CLK;
      build_tests();
      repeat (16) @(posedge clk1);
      #10;
      rst_n = 1'b1;
      @(posedge clk1);
      #10;
      check_data("wait_out", 32'h0, 32'(wait_out));
      check_data("access_out", 32'h0, 32'(access_out));
      check_data("clkout", 32'h1, 32'(clkout));        // High just after the edge
      #50;
      check_data("clkout", 32'h0, 32'(clkout));        // Low past the falling edge
      @(posedge clk1);
      #10;
      foreach (tests[i]) begin
         e = tests[i];
         op = e.op;
         err0 = errors;
         case (op)
            OP_BP: begin
               if (!e.exp_val[0])
                  wait_drain();                // Burst must fully arrive
               bp_on = e.exp_val[0];
            end
            OP_WR: begin
               send_packet(e.pkt);
               if (e.pkt.dstaddr == REG_CFG) model_en = e.pkt.data[12];
               if (e.pkt.dstaddr == REG_CLK) model_div = e.pkt.data[6:0];
               if (!bp_on) check_quiet(4);     // Writes give no reply
            end
            OP_RD: begin
               exp_q.push_back(expected_response(e.pkt, e.exp_val));
               rsp_q.push_back(1'b1);
               send_packet(e.pkt);
               if (!bp_on) wait_drain();
            end
            default: begin
               if (model_en) begin
                  exp_q.push_back(e.pkt);       // Loopback is exact
                  rsp_q.push_back(1'b0);
               end
               send_packet(e.pkt);
               if (!model_en) begin
                  check_quiet(TIMEOUT);
               end else if (!bp_on) begin
                  wait_rise(lat);
                  checks++;
                  if (lat < BEATS * (model_div + 1)) begin
                     errors++;
                     $display("Packet looped back after %0d cycles, faster than pacing", lat);
                  end
                  wait_drain();
               end
            end
         endcase
         $display("test %0d %s %s", i, op.name(), (errors == err0) ? "ok" : "failed");
      end
      wait_drain();
      $display("%0d tests, %0d checks, %0d outputs, %0d errors",
               tests.size(), checks, outputs_seen, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: mio_dut.f
verilog/emesh_pkg.sv
verilog/mio_pkg.sv
verilog/mio_tx.sv
verilog/mio_regs.sv
verilog/mio_rx.sv
verilog/mio_dut.sv
tb/tb_mio_dut.sv
